// File: Bender.yml
package:
  name: uart_wb

# RTL top is uart_top, testbench top is tb_uart
sources:
  - uart_line_pkg.sv
  - uart_bus_pkg.sv
  - uart_baud_gen.sv
  - uart_tx_fifo.sv
  - uart_tx_serializer.sv
  - uart_rx_deserializer.sv
  - uart_wb_regs.sv
  - uart_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_uart.sv

// File: all.f
uart_line_pkg.sv
uart_bus_pkg.sv
uart_baud_gen.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
uart_rx_deserializer.sv
uart_wb_regs.sv
uart_top.sv
tb_clkgen.sv
tb_uart.sv

// File: tb_clkgen.sv
/*
  Testbench clock and reset source. Free-running clk with a period of
  20 units, aresetn held low for the first 5 rising edges.
*/
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic aresetn
);

  localparam int half_period = 10;
  localparam int reset_cycles = 5;

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release 2 units after the edge like every other driven input
  initial
  begin
    aresetn = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    aresetn = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_uart.sv
/*
  UART testbench. Reads uart_stim.txt line by line and runs Wishbone
  writes and reads, raw rx frames and tx drains against uart_top.
  A background monitor decodes every tx frame and checks it against the
  bytes written, in the format last written to the control register.
*/
`default_nettype none

module tb_uart
  import uart_bus_pkg::*;
();

  // cycles to wait for ack before giving up
  localparam int ack_limit = 16;

  logic                     clk;
  logic                     aresetn;
  logic                     cyc;
  logic                     stb;
  logic                     we;
  logic [wb_addr_width-1:0] adr;
  logic [wb_data_width-1:0] dat_w;
  logic [wb_data_width-1:0] dat_r;
  logic                     ack;
  logic                     tx;
  logic                     rx_line;
  logic                     rx_drv;
  logic                     loop_en;
  logic                     tx_prev = 1'b1;

  // line format as last written to ctrl
  int                       fmt_div;
  logic                     fmt_bit8;
  logic                     fmt_pe;
  logic                     fmt_odd;
  int                       bit_clks;

  // bytes written and not yet seen on tx
  logic [7:0]               tx_expect [$];
  int                       err_bus;
  int                       err_tx;
  int                       err_other;

  tb_clkgen clkgen0 (
    .clk, .aresetn
  );

  uart_top dut0 (
    .clk, .aresetn, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .tx, .rx(rx_line)
  );

  // loopback feeds tx straight back into rx
  assign rx_line = loop_en ? tx : rx_drv;

  // parity over 7 or 8 data bits, odd flips it
  function automatic logic frame_parity(input logic [7:0] data, input logic bit8,
                                        input logic odd);
    logic p;
    p = bit8 ? ^data : ^data[6:0];
    return p ^ odd;
  endfunction

  // ctrl word is divisor[15:4], bit8, parity_en, odd_n_even, reserved
  task automatic set_format(input logic [15:0] w);
    fmt_div  = w[15:4];
    fmt_bit8 = w[3];
    fmt_pe   = w[2];
    fmt_odd  = w[1];
    bit_clks = 16 * (fmt_div + 1);
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // ------------------------------
  // Wishbone classic cycle, held until ack
  task automatic bus_cycle(input logic wr, input logic [1:0] a, input logic [15:0] d,
                           output logic [15:0] rd);
    int cnt;
    @(posedge clk);
    #2;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    cnt   = 0;
    @(posedge clk);
    #1;
    // ack due one cycle after the strobe
    assert (ack === 1'b1)
    else
    begin
      $display("FAIL t=%0t ack (adr %0d) got %b exp 1", $time, a, ack);
      err_bus++;
    end
    while (!ack && cnt < ack_limit)
    begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!ack)
    begin
      $display("ERROR t=%0t no ack for bus cycle to address %0d", $time, a);
      err_other++;
    end
    // dat_r only valid while ack is high
    rd = dat_r;
    @(posedge clk);
    #2;
    // ack lasts a single cycle
    assert (ack === 1'b0)
    else
    begin
      $display("FAIL t=%0t ack (adr %0d) got %b exp 0", $time, a, ack);
      err_bus++;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] a, input logic [15:0] d);
    logic [15:0] unused_rd;
    bus_cycle(1'b1, a, d, unused_rd);
  endtask

  task automatic check_read(input logic [1:0] a, input logic [15:0] exp);
    logic [15:0] got;
    bus_cycle(1'b0, a, 16'h0000, got);
    assert (got === exp)
    else
    begin
      $display("FAIL t=%0t dat_r (adr %0d) got %h exp %h", $time, a, got, exp);
      err_bus++;
    end
  endtask

  // ------------------------------
  // raw rx frames, one bit period per bit
  task automatic drive_rx_bit(input logic v);
    @(posedge clk);
    #2;
    rx_drv = v;
    repeat (bit_clks - 1) @(posedge clk);
  endtask

  task automatic send_rx_frame(input logic [7:0] data, input logic corrupt);
    int nbits;
    int i;
    nbits = fmt_bit8 ? 8 : 7;
    drive_rx_bit(1'b0);
    for (i = 0; i < nbits; i++)
      drive_rx_bit(data[i]);
    if (fmt_pe)
      drive_rx_bit(frame_parity(data, fmt_bit8, fmt_odd) ^ corrupt);
    drive_rx_bit(1'b1);
  endtask

  // wait for every expected byte to leave tx
  task automatic drain_tx();
    int limit;
    int cnt;
    // frame plus the idle gap is well under 16 bit periods
    limit = (tx_expect.size() + 1) * 16 * bit_clks;
    cnt   = 0;
    while (tx_expect.size() != 0 && cnt < limit)
    begin
      @(posedge clk);
      cnt++;
    end
    if (tx_expect.size() != 0)
    begin
      $display("ERROR t=%0t timed out with %0d tx bytes never sent", $time,
               tx_expect.size());
      err_other++;
      tx_expect.delete();
    end
    // receiver reaches mid stop within a bit period
    wait_clks(bit_clks);
  endtask

  // ------------------------------
  // tx monitor, starts at the falling edge and samples mid-bit
  task automatic decode_frame();
    logic [7:0] got;
    logic [7:0] exp;
    logic       par_got;
    logic       par_exp;
    int         nbits;
    int         i;
    got     = 8'h00;
    par_got = 1'b0;
    nbits   = fmt_bit8 ? 8 : 7;
    wait_clks(bit_clks / 2);
    assert (tx === 1'b0)
    else
    begin
      $display("FAIL t=%0t tx start bit got %b exp 0", $time, tx);
      err_tx++;
    end
    for (i = 0; i < nbits; i++)
    begin
      wait_clks(bit_clks);
      got[i] = tx;
    end
    if (fmt_pe)
    begin
      wait_clks(bit_clks);
      par_got = tx;
    end
    wait_clks(bit_clks);
    assert (tx === 1'b1)
    else
    begin
      $display("FAIL t=%0t tx stop bit got %b exp 1", $time, tx);
      err_tx++;
    end
    if (tx_expect.size() == 0)
    begin
      $display("ERROR t=%0t tx sent byte %h but nothing was written", $time, got);
      err_tx++;
    end
    else
    begin
      exp = tx_expect.pop_front();
      // 7-bit mode never sends bit 7
      if (!fmt_bit8)
        exp[7] = 1'b0;
      par_exp = frame_parity(exp, fmt_bit8, fmt_odd);
      assert (got === exp)
      else
      begin
        $display("FAIL t=%0t tx data got %h exp %h", $time, got, exp);
        err_tx++;
      end
      if (fmt_pe)
      begin
        assert (par_got === par_exp)
        else
        begin
          $display("FAIL t=%0t tx parity got %b exp %b", $time, par_got, par_exp);
          err_tx++;
        end
      end
    end
  endtask

  always @(posedge clk)
  begin
    #1;
    if (aresetn && tx_prev && !tx)
      decode_frame();
    tx_prev = tx;
  end

  // ------------------------------
  // one stimulus line
  task automatic run_command(input logic [7:0] cmd, input logic [31:0] a,
                             input logic [31:0] b);
    case (cmd)
      "W":
      begin
        if (a[1:0] == addr_ctrl)
          set_format(b[15:0]);
        if (a[1:0] == addr_data)
          tx_expect.push_back(b[7:0]);
        bus_write(a[1:0], b[15:0]);
      end
      // data write that a full FIFO drops
      "X": bus_write(addr_data, b[15:0]);
      "R": check_read(a[1:0], b[15:0]);
      "F": send_rx_frame(a[7:0], b[0]);
      "L":
      begin
        @(posedge clk);
        #2;
        loop_en = a[0];
      end
      "D": drain_tx();
      default:
      begin
        $display("ERROR unknown command %c in stimulus file", cmd);
        err_other++;
      end
    endcase
  endtask

  initial
  begin
    int               fd;
    int               n;
    int               cnt;
    logic [7:0]       cmd;
    logic [31:0]      arg_a;
    logic [31:0]      arg_b;
    logic [8*120-1:0] skip_line;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    dat_w     = '0;
    rx_drv    = 1'b1;
    loop_en   = 1'b0;
    err_bus   = 0;
    err_tx    = 0;
    err_other = 0;
    // ctrl resets to zero
    set_format(16'h0000);

    cnt = 0;
    while (aresetn !== 1'b1 && cnt < 20)
    begin
      @(posedge clk);
      cnt++;
    end
    if (aresetn !== 1'b1)
    begin
      $display("ERROR reset was never released");
      err_other++;
    end

    // idle line after reset
    repeat (8)
    begin
      @(posedge clk);
      #1;
      assert (tx === 1'b1)
      else
      begin
        $display("FAIL t=%0t tx got %b exp 1", $time, tx);
        err_tx++;
      end
    end

    fd = $fopen("uart_stim.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR could not open stimulus file uart_stim.txt");
      err_other++;
    end
    else
    begin
      while ($fscanf(fd, " %c", cmd) == 1)
      begin
        if (cmd == "#")
          n = $fgets(skip_line, fd);
        else
        begin
          n = $fscanf(fd, "%h %h", arg_a, arg_b);
          if (n != 2)
          begin
            $display("ERROR stimulus line for command %c has missing fields", cmd);
            err_other++;
          end
          else
            run_command(cmd, arg_a, arg_b);
        end
      end
      $fclose(fd);
    end

    $display("errors: bus %0d, tx %0d, other %0d", err_bus, err_tx, err_other);
    if (err_bus + err_tx + err_other == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_baud_gen.sv
/*
  Baud generator. Makes a 16x oversample tick every divisor + 1 clocks
  and a one-per-bit pulse on every 16th tick, shared by tx and rx.
*/
`default_nettype none

module uart_baud_gen
  import uart_line_pkg::*;
(
  input  wire                 clk,
  input  wire                 aresetn,
  input  wire [div_width-1:0] divisor,
  output logic                tick,
  output logic                bit_pulse
);

  logic [div_width-1:0]          div_cnt;
  logic [$clog2(oversample)-1:0] tick_cnt;

  // reloading down-counter, tick on reload
  // bit_pulse rides on the tick that wraps tick_cnt
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      div_cnt   <= '0;
      tick_cnt  <= '0;
      tick      <= 1'b0;
      bit_pulse <= 1'b0;
    end
    else if (div_cnt == '0)
    begin
      div_cnt   <= divisor;
      tick      <= 1'b1;
      tick_cnt  <= tick_cnt + 1'b1;
      bit_pulse <= (tick_cnt == oversample - 1);
    end
    else
    begin
      div_cnt   <= div_cnt - 1'b1;
      tick      <= 1'b0;
      bit_pulse <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: uart_bus_pkg.sv
/*
  Wishbone side definitions: register map, register word layout, status
  bit positions and transmit FIFO depth. Used by the register block and top.
*/
`default_nettype none

package uart_bus_pkg;

  localparam int wb_data_width = 16;
  localparam int wb_addr_width = 2;

  // register map
  localparam logic [wb_addr_width-1:0] addr_data   = 2'd0;
  localparam logic [wb_addr_width-1:0] addr_ctrl   = 2'd1;
  localparam logic [wb_addr_width-1:0] addr_status = 2'd2;

  localparam int tx_fifo_depth = 8;

  // status word bit positions
  localparam int bit_tx_full    = 0;
  localparam int bit_tx_empty   = 1;
  localparam int bit_rx_valid   = 2;
  localparam int bit_parity_err = 3;
  localparam int bit_overrun    = 4;

  // control word, msb first
  typedef struct packed {
    logic [uart_line_pkg::div_width-1:0] divisor;
    logic                                bit8;
    logic                                parity_en;
    logic                                odd_n_even;
    logic                                reserved;
  } uart_ctrl_t;

  // one write word, read as control at addr_ctrl, as a byte at addr_data
  typedef union packed {
    uart_ctrl_t ctrl;
    struct packed {
      logic [7:0] pad;
      logic [7:0] data_byte;
    } data;
  } uart_wb_word_u;

endpackage

`default_nettype wire

// File: uart_line_pkg.sv
/*
  Serial line definitions shared by the baud generator, the transmit
  serializer and the receive deserializer. Import with uart_line_pkg::*.
*/
`default_nettype none

package uart_line_pkg;

  // ticks per bit, both directions
  localparam int oversample = 16;

  // baud divisor width, tick period is divisor + 1 clocks
  localparam int div_width = 12;

  // frame phases
  // rx walks idle, start, data, parity, stop only
  typedef enum logic [2:0] {
    fs_idle   = 3'd0,
    fs_load   = 3'd1,
    fs_start  = 3'd2,
    fs_data   = 3'd3,
    fs_parity = 3'd4,
    fs_stop   = 3'd5,
    fs_fetch  = 3'd6
  } frame_state_t;

endpackage

`default_nettype wire

// File: uart_rx_deserializer.sv
/*
  Receive deserializer. Syncs rx, confirms the start bit at mid-bit,
  samples every 16 ticks, checks parity and holds one byte until read.
*/
`default_nettype none

module uart_rx_deserializer
  import uart_line_pkg::*;
(
  input  wire        clk,
  input  wire        aresetn,
  input  wire        tick,
  input  wire        rx,
  input  wire        bit8,
  input  wire        parity_en,
  input  wire        odd_n_even,
  input  wire        read_ack,
  input  wire        status_read,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       parity_err,
  output logic       overrun
);

  frame_state_t                  state;
  logic                          rx_meta;
  logic                          rx_sync;
  logic [$clog2(oversample)-1:0] tick_cnt;
  logic [2:0]                    bit_cnt;
  logic [7:0]                    shift;
  logic                          run_par;
  logic                          par_bad;
  logic                          at_sample;
  logic                          last_bit;
  logic                          frame_done;
  logic                          accept;

  assign at_sample  = tick && (tick_cnt == oversample - 1);
  assign last_bit   = bit8 ? (bit_cnt == 3'd7) : (bit_cnt == 3'd6);
  // mid stop bit
  assign frame_done = (state == fs_stop) && at_sample;
  // held byte is free, or being read right now
  assign accept     = frame_done && (!rx_valid || read_ack);

  // two-flop synchronizer, idles high
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // ------------------------------
  // frame state machine, moves on ticks
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state    <= fs_idle;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      run_par  <= 1'b0;
      par_bad  <= 1'b0;
    end
    else if (tick)
    begin
      tick_cnt <= tick_cnt + 1'b1;
      case (state)
        fs_idle:
        begin
          tick_cnt <= '0;
          run_par  <= 1'b0;
          par_bad  <= 1'b0;
          if (!rx_sync)
            state <= fs_start;
        end
        fs_start:
        begin
          // mid start bit, a high line here was a glitch
          if (tick_cnt == oversample / 2 - 1)
          begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? fs_idle : fs_data;
          end
        end
        fs_data:
        begin
          if (tick_cnt == oversample - 1)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            run_par <= run_par ^ rx_sync;
            if (last_bit)
              state <= parity_en ? fs_parity : fs_stop;
          end
        end
        fs_parity:
        begin
          if (tick_cnt == oversample - 1)
          begin
            par_bad <= rx_sync ^ run_par ^ odd_n_even;
            state   <= fs_stop;
          end
        end
        fs_stop:
          if (tick_cnt == oversample - 1)
            state <= fs_idle;
        default:
          state <= fs_idle;
      endcase
    end
  end

  // data shifts in from the top, lsb first on the line
  always_ff @(posedge clk)
  begin
    if (at_sample && state == fs_data)
      shift <= {rx_sync, shift[7:1]};
    // 7-bit frames end one place high
    if (accept)
      rx_byte <= bit8 ? shift : {1'b0, shift[7:1]};
  end

  // ------------------------------
  // holding flags
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_valid   <= 1'b0;
      parity_err <= 1'b0;
      overrun    <= 1'b0;
    end
    else
    begin
      if (read_ack)
      begin
        rx_valid   <= 1'b0;
        parity_err <= 1'b0;
      end
      if (status_read)
        overrun <= 1'b0;
      if (accept)
      begin
        rx_valid   <= 1'b1;
        parity_err <= par_bad;
      end
      else if (frame_done)
        overrun <= 1'b1;    // old byte stays
    end
  end

endmodule

`default_nettype wire

// File: uart_stim.txt
# cmd a b in hex. W adr data bus write, X adr data write dropped by a full FIFO
# R adr exp bus read and compare, F byte corrupt rx frame, L on 0 loopback, D 0 0 drain tx
R 2 0002
# 8-bit, no parity, divisor 3
W 1 0038
R 1 0038
W 0 55
W 0 A3
D 0 0
# 8-bit, even parity
W 1 003C
W 0 96
W 0 01
D 0 0
# 8-bit, odd parity
W 1 003E
W 0 7F
W 0 80
D 0 0
# 7-bit, even parity, looped back
W 1 0034
L 1 0
W 0 C5
D 0 0
L 0 0
R 2 0006
R 0 0045
R 2 0002
# fill the FIFO while the first byte is on the line
W 1 0038
W 0 11
W 0 21
W 0 22
W 0 23
W 0 24
W 0 25
W 0 26
W 0 27
W 0 28
X 0 29
X 0 2A
R 2 0001
D 0 0
R 2 0002
# rx parity error
W 1 003C
F 5A 1
R 2 000E
R 0 005A
R 2 0002
# rx overrun
F 3C 0
F C3 0
R 0 003C
R 2 0012
R 2 0002

// File: uart_top.sv
/*
  UART top. Wishbone register block, tx FIFO, baud generator,
  transmit serializer and receive deserializer, all on clk.
*/
`default_nettype none

module uart_top
  import uart_line_pkg::*;
  import uart_bus_pkg::*;
(
  input  wire                      clk,
  input  wire                      aresetn,
  input  wire                      cyc,
  input  wire                      stb,
  input  wire                      we,
  input  wire  [wb_addr_width-1:0] adr,
  input  wire  [wb_data_width-1:0] dat_w,
  output logic [wb_data_width-1:0] dat_r,
  output logic                     ack,
  output logic                     tx,
  input  wire                      rx
);

  // fifo side
  logic                 push;
  logic [7:0]           push_byte;
  logic                 pop;
  logic [7:0]           head_byte;
  logic                 empty;
  logic                 full;
  // baud
  logic                 tick;
  logic                 bit_pulse;
  // receiver
  logic [7:0]           rx_byte;
  logic                 rx_valid;
  logic                 parity_err;
  logic                 overrun;
  logic                 read_ack;
  logic                 status_read;
  // shared format
  logic [div_width-1:0] divisor;
  logic                 bit8;
  logic                 parity_en;
  logic                 odd_n_even;

  uart_wb_regs regs0 (
    .clk, .aresetn, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .push, .push_byte, .full, .empty,
    .rx_byte, .rx_valid, .parity_err, .overrun, .read_ack, .status_read,
    .divisor, .bit8, .parity_en, .odd_n_even
  );

  uart_tx_fifo fifo0 (
    .clk, .aresetn, .push, .push_byte, .pop, .head_byte, .empty, .full
  );

  uart_baud_gen baud0 (
    .clk, .aresetn, .divisor, .tick, .bit_pulse
  );

  uart_tx_serializer txs0 (
    .clk, .aresetn, .bit_pulse, .empty, .head_byte,
    .bit8, .parity_en, .odd_n_even, .pop, .tx
  );

  uart_rx_deserializer rxd0 (
    .clk, .aresetn, .tick, .rx, .bit8, .parity_en, .odd_n_even,
    .read_ack, .status_read, .rx_byte, .rx_valid, .parity_err, .overrun
  );

endmodule

`default_nettype wire

// File: uart_tx_fifo.sv
/*
  Transmit FIFO between the register block and the serializer.
  Push and pop take effect on the next edge, head_byte shows the oldest entry.
*/
`default_nettype none

module uart_tx_fifo
  import uart_bus_pkg::*;
(
  input  wire        clk,
  input  wire        aresetn,
  input  wire        push,
  input  wire  [7:0] push_byte,
  input  wire        pop,
  output logic [7:0] head_byte,
  output logic       empty,
  output logic       full
);

  logic [7:0]                         mem [tx_fifo_depth];
  logic [$clog2(tx_fifo_depth)-1:0]   wr_ptr;
  logic [$clog2(tx_fifo_depth)-1:0]   rd_ptr;
  logic [$clog2(tx_fifo_depth):0]     count;
  logic                               wr_en;
  logic                               rd_en;

  assign wr_en     = push && !full;
  assign rd_en     = pop && !empty;
  assign empty     = (count == 0);
  assign full      = (count == tx_fifo_depth);
  assign head_byte = mem[rd_ptr];

  // storage
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_byte;
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------
  // serializer pops only a filled FIFO, register block never pushes into a full one
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!aresetn) pop |-> !empty);
  a_no_push_full: assert property (@(posedge clk) disable iff (!aresetn) push |-> !full);

endmodule

`default_nettype wire

// File: uart_tx_serializer.sv
/*
  Transmit serializer. Pops a byte from the FIFO and frames it on tx:
  start bit, 7 or 8 data bits lsb first, optional parity, one stop bit.
  idle, fetch and load run on clk; the bit phases advance on bit_pulse.
*/
`default_nettype none

module uart_tx_serializer
  import uart_line_pkg::*;
(
  input  wire        clk,
  input  wire        aresetn,
  input  wire        bit_pulse,
  input  wire        empty,
  input  wire  [7:0] head_byte,
  input  wire        bit8,
  input  wire        parity_en,
  input  wire        odd_n_even,
  output logic       pop,
  output logic       tx
);

  frame_state_t state;
  logic [7:0]   tx_byte;
  logic [2:0]   bit_sel;
  logic         tx_parity;
  logic         last_bit;

  // 7 or 8 data bits
  assign last_bit = bit8 ? (bit_sel == 3'd7) : (bit_sel == 3'd6);

  // ------------------------------
  // frame state machine
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state <= fs_idle;
      pop   <= 1'b0;
    end
    else
    begin
      pop <= 1'b0;
      case (state)
        fs_idle:
        begin
          // pop strobe is high for the single fetch cycle
          if (!empty)
          begin
            pop   <= 1'b1;
            state <= fs_fetch;
          end
        end
        fs_fetch:
          state <= fs_load;
        fs_load:
          if (bit_pulse)
            state <= fs_start;
        fs_start:
          if (bit_pulse)
            state <= fs_data;
        fs_data:
        begin
          if (bit_pulse && last_bit)
            state <= parity_en ? fs_parity : fs_stop;
        end
        fs_parity:
          if (bit_pulse)
            state <= fs_stop;
        fs_stop:
          if (bit_pulse)
            state <= fs_idle;
        default:
          state <= fs_idle;
      endcase
    end
  end

  // head byte taken on the edge that pops it
  always_ff @(posedge clk)
  begin
    if (state == fs_fetch)
      tx_byte <= head_byte;
  end

  // bit selector, counts only through the data phase
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      bit_sel <= '0;
    else if (bit_pulse)
      bit_sel <= (state == fs_data) ? bit_sel + 1'b1 : 3'd0;
  end

  // ------------------------------
  // line driver, one phase behind the state
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      tx <= 1'b1;
    else
    begin
      case (state)
        fs_start:  if (bit_pulse) tx <= 1'b0;
        fs_data:   if (bit_pulse) tx <= tx_byte[bit_sel];
        fs_parity: if (bit_pulse) tx <= odd_n_even ^ tx_parity;
        fs_stop:   if (bit_pulse) tx <= 1'b1;
        default:   tx <= 1'b1;
      endcase
    end
  end

  // running even parity, cleared in stop
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      tx_parity <= 1'b0;
    else if (state == fs_stop)
      tx_parity <= 1'b0;
    else if (bit_pulse && state == fs_data)
      tx_parity <= tx_parity ^ tx_byte[bit_sel];
  end

  // stop bit has reached the line by the time we are back in idle
  a_idle_line_high: assert property (@(posedge clk) disable iff (!aresetn)
    state == fs_idle |-> tx);

endmodule

`default_nettype wire

// File: uart_wb_regs.sv
/*
  Wishbone classic slave. Decodes data, control and status registers,
  pushes written bytes to the tx FIFO and signals reads to the receiver.
  ack follows the request by one cycle, read data registers on the same edge.
*/
`default_nettype none

module uart_wb_regs
  import uart_line_pkg::*;
  import uart_bus_pkg::*;
(
  input  wire                      clk,
  input  wire                      aresetn,
  input  wire                      cyc,
  input  wire                      stb,
  input  wire                      we,
  input  wire  [wb_addr_width-1:0] adr,
  input  wire  [wb_data_width-1:0] dat_w,
  output logic [wb_data_width-1:0] dat_r,
  output logic                     ack,
  output logic                     push,
  output logic [7:0]               push_byte,
  input  wire                      full,
  input  wire                      empty,
  input  wire  [7:0]               rx_byte,
  input  wire                      rx_valid,
  input  wire                      parity_err,
  input  wire                      overrun,
  output logic                     read_ack,
  output logic                     status_read,
  output logic [div_width-1:0]     divisor,
  output logic                     bit8,
  output logic                     parity_en,
  output logic                     odd_n_even
);

  uart_wb_word_u            wb_word;
  uart_ctrl_t               ctrl_q;
  logic                     req;
  logic                     wr_req;
  logic                     rd_req;
  logic [wb_data_width-1:0] status_word;

  assign wb_word = dat_w;
  // no new request in the ack cycle, gives the one-cycle gap
  assign req     = cyc && stb && !ack;
  assign wr_req  = req && we;
  assign rd_req  = req && !we;

  always_comb
  begin
    status_word                 = '0;
    status_word[bit_tx_full]    = full;
    status_word[bit_tx_empty]   = empty;
    status_word[bit_rx_valid]   = rx_valid;
    status_word[bit_parity_err] = parity_err;
    status_word[bit_overrun]    = overrun;
  end

  // ------------------------------
  // strobes and control word
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      ack         <= 1'b0;
      push        <= 1'b0;
      read_ack    <= 1'b0;
      status_read <= 1'b0;
      ctrl_q      <= '0;
    end
    else
    begin
      ack         <= req;
      // full FIFO drops the byte, cycle still acks
      push        <= wr_req && (adr == addr_data) && !full;
      read_ack    <= rd_req && (adr == addr_data);
      status_read <= rd_req && (adr == addr_status);
      if (wr_req && adr == addr_ctrl)
        ctrl_q <= wb_word.ctrl;
    end
  end

  // write byte and read word
  always_ff @(posedge clk)
  begin
    if (wr_req && adr == addr_data)
      push_byte <= wb_word.data.data_byte;
    if (rd_req)
    begin
      case (adr)
        addr_data:   dat_r <= {8'h00, rx_byte};
        addr_ctrl:   dat_r <= ctrl_q;
        addr_status: dat_r <= status_word;
        default:     dat_r <= '0;
      endcase
    end
  end

  assign divisor    = ctrl_q.divisor;
  assign bit8       = ctrl_q.bit8;
  assign parity_en  = ctrl_q.parity_en;
  assign odd_n_even = ctrl_q.odd_n_even;

  // master holds the cycle until it sees ack
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!aresetn) ack |-> cyc && stb);

endmodule

`default_nettype wire
